// ==== Makefile ====
# Verilator flow for the AXI memory subsystem.
VERILATOR ?= verilator
TOP       ?= tb_axi_mem
RTL_TOP   ?= axi_mem_top
SEED      ?= 1794888984
LOG       ?= sim.log
BUILD     ?= obj_dir
FLIST     ?= src.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FLIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hdl/axi_burst_addr.sv ====
`timescale 1ns/1ps

module axi_burst_addr import axi_mem_pkg::*; (
    input  addr_t                 addr_i,
    input  logic [AXI_SIZE_W-1:0] size_i,
    input  logic [AXI_LEN_W-1:0]  len_i,
    input  burst_e                burst_i,
    output addr_t                 next_addr_o
);

    addr_t step;
    addr_t incr_addr;
    addr_t wrap_mask;

    always_comb begin
        step      = addr_t'(1) << size_i;
        // Beats after the first start from the size-aligned address.
        incr_addr = (addr_i & ~(step - addr_t'(1))) + step;

        case (len_i)
            8'd1: begin
                wrap_mask = (addr_t'(2) << size_i) - addr_t'(1);
            end
            8'd3: begin
                wrap_mask = (addr_t'(4) << size_i) - addr_t'(1);
            end
            8'd7: begin
                wrap_mask = (addr_t'(8) << size_i) - addr_t'(1);
            end
            8'd15: begin
                wrap_mask = (addr_t'(16) << size_i) - addr_t'(1);
            end
            default: begin
                wrap_mask = '1;    // An illegal wrap length behaves as INCR.
            end
        endcase

        case (burst_i)
            BURST_FIXED: begin
                next_addr_o = addr_i;
            end
            BURST_WRAP: begin
                next_addr_o = (addr_i & ~wrap_mask) | (incr_addr & wrap_mask);
            end
            default: begin
                next_addr_o = incr_addr;
            end
        endcase
    end

endmodule

// ==== hdl/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model import axi_mem_pkg::*; (
    input logic       clk_i,
    mem_bus_if.memory mem
);

    data_t mem_q [MEM_WORDS];
    data_t rdata_q;
    logic  rvalid_q;

    // Every request is accepted at once.
    assign mem.gnt    = mem.req;
    assign mem.rvalid = rvalid_q;
    assign mem.rdata  = rdata_q;

    always_ff @(posedge clk_i) begin
        rvalid_q <= mem.req;  // Read data or write acknowledge.
        if (mem.req && !mem.we) begin
            rdata_q <= mem_q[mem.idx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem.req && mem.we) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (mem.strb[b]) begin
                    mem_q[mem.idx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/axi_mem_pkg.sv ====
package axi_mem_pkg;

    // AXI bus widths.
    localparam int AXI_ADDR_W = 16;
    localparam int AXI_DATA_W = 64;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_LEN_W  = 8;
    localparam int AXI_SIZE_W = 3;

    // Memory of 8 KiB in 64-bit words.
    localparam int MEM_WORDS = 1024;
    localparam int MEM_IDX_W = 10;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef logic [AXI_ADDR_W-1:0] addr_t;
    typedef logic [AXI_DATA_W-1:0] data_t;
    typedef logic [AXI_STRB_W-1:0] strb_t;
    typedef logic [AXI_ID_W-1:0]   id_t;

endpackage

// ==== hdl/axi_mem_top.sv ====
`timescale 1ns/1ps

module axi_mem_top import axi_mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  id_t                   s_axi_awid_i,
    input  addr_t                 s_axi_awaddr_i,
    input  logic [AXI_LEN_W-1:0]  s_axi_awlen_i,
    input  logic [AXI_SIZE_W-1:0] s_axi_awsize_i,
    input  logic [1:0]            s_axi_awburst_i,
    input  logic                  s_axi_awvalid_i,
    output logic                  s_axi_awready_o,
    input  data_t                 s_axi_wdata_i,
    input  strb_t                 s_axi_wstrb_i,
    input  logic                  s_axi_wlast_i,
    input  logic                  s_axi_wvalid_i,
    output logic                  s_axi_wready_o,
    output id_t                   s_axi_bid_o,
    output logic [1:0]            s_axi_bresp_o,
    output logic                  s_axi_bvalid_o,
    input  logic                  s_axi_bready_i,
    input  id_t                   s_axi_arid_i,
    input  addr_t                 s_axi_araddr_i,
    input  logic [AXI_LEN_W-1:0]  s_axi_arlen_i,
    input  logic [AXI_SIZE_W-1:0] s_axi_arsize_i,
    input  logic [1:0]            s_axi_arburst_i,
    input  logic                  s_axi_arvalid_i,
    output logic                  s_axi_arready_o,
    output id_t                   s_axi_rid_o,
    output data_t                 s_axi_rdata_o,
    output logic [1:0]            s_axi_rresp_o,
    output logic                  s_axi_rlast_o,
    output logic                  s_axi_rvalid_o,
    input  logic                  s_axi_rready_i
);

    mem_bus_if mem_bus ();

    axi_to_mem i_axi_to_mem (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .aw_id_i    (s_axi_awid_i),
        .aw_addr_i  (s_axi_awaddr_i),
        .aw_len_i   (s_axi_awlen_i),
        .aw_size_i  (s_axi_awsize_i),
        .aw_burst_i (burst_e'(s_axi_awburst_i)),
        .aw_valid_i (s_axi_awvalid_i),
        .aw_ready_o (s_axi_awready_o),
        .w_data_i   (s_axi_wdata_i),
        .w_strb_i   (s_axi_wstrb_i),
        .w_last_i   (s_axi_wlast_i),
        .w_valid_i  (s_axi_wvalid_i),
        .w_ready_o  (s_axi_wready_o),
        .b_id_o     (s_axi_bid_o),
        .b_resp_o   (s_axi_bresp_o),
        .b_valid_o  (s_axi_bvalid_o),
        .b_ready_i  (s_axi_bready_i),
        .ar_id_i    (s_axi_arid_i),
        .ar_addr_i  (s_axi_araddr_i),
        .ar_len_i   (s_axi_arlen_i),
        .ar_size_i  (s_axi_arsize_i),
        .ar_burst_i (burst_e'(s_axi_arburst_i)),
        .ar_valid_i (s_axi_arvalid_i),
        .ar_ready_o (s_axi_arready_o),
        .r_id_o     (s_axi_rid_o),
        .r_data_o   (s_axi_rdata_o),
        .r_resp_o   (s_axi_rresp_o),
        .r_last_o   (s_axi_rlast_o),
        .r_valid_o  (s_axi_rvalid_o),
        .r_ready_i  (s_axi_rready_i),
        .mem        (mem_bus.requester)
    );

    axi_mem_model i_mem_model (
        .clk_i (clk_i),
        .mem   (mem_bus.memory)
    );

endmodule

// ==== hdl/axi_to_mem.sv ====
`timescale 1ns/1ps

module axi_to_mem import axi_mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  id_t                   aw_id_i,
    input  addr_t                 aw_addr_i,
    input  logic [AXI_LEN_W-1:0]  aw_len_i,
    input  logic [AXI_SIZE_W-1:0] aw_size_i,
    input  burst_e                aw_burst_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    input  data_t                 w_data_i,
    input  strb_t                 w_strb_i,
    input  logic                  w_last_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,
    output id_t                   b_id_o,
    output resp_e                 b_resp_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i,
    input  id_t                   ar_id_i,
    input  addr_t                 ar_addr_i,
    input  logic [AXI_LEN_W-1:0]  ar_len_i,
    input  logic [AXI_SIZE_W-1:0] ar_size_i,
    input  burst_e                ar_burst_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    output id_t                   r_id_o,
    output data_t                 r_data_o,
    output resp_e                 r_resp_o,
    output logic                  r_last_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    mem_bus_if.requester          mem
);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_WRESP, ST_READ} state_e;

    state_e                state_q;
    logic                  rr_rd_q;      // Last burst served was a read.
    logic                  done_q;       // All beats of the burst issued.
    logic                  err_q;
    logic                  derr_q;       // Out-of-range beat issued last cycle.
    logic                  last_pend_q;
    id_t                   id_q;
    addr_t                 addr_q;
    addr_t                 next_addr;
    logic [AXI_LEN_W-1:0]  len_q;
    logic [AXI_LEN_W-1:0]  cnt_q;        // Beats left after the current one.
    logic [AXI_SIZE_W-1:0] size_q;
    burst_e                burst_q;

    data_t                 fifo_data_q [2];
    resp_e                 fifo_resp_q [2];
    logic                  fifo_last_q [2];
    logic                  wr_ptr_q;
    logic                  rd_ptr_q;
    logic [1:0]            fifo_cnt_q;

    logic                  wr_sel;
    logic                  aw_fire;
    logic                  ar_fire;
    logic                  w_fire;
    logic                  rd_issue;
    logic                  beat_fire;
    logic                  beat_last;
    logic                  oor;
    logic                  resp_arrive;
    logic                  r_push;
    logic                  r_pop;
    logic [1:0]            occ;

    assign wr_sel     = aw_valid_i && (!ar_valid_i || rr_rd_q);
    assign aw_ready_o = (state_q == ST_IDLE) && wr_sel;
    assign ar_ready_o = (state_q == ST_IDLE) && ar_valid_i && !wr_sel;
    assign aw_fire    = aw_valid_i && aw_ready_o;
    assign ar_fire    = ar_valid_i && ar_ready_o;

    assign oor         = addr_q >= addr_t'(MEM_WORDS * AXI_STRB_W);
    assign resp_arrive = mem.rvalid || derr_q;
    assign occ         = fifo_cnt_q + {1'b0, resp_arrive};  // Buffered plus in flight.
    assign r_pop       = r_valid_o && r_ready_i;
    assign r_push      = (state_q == ST_READ) && resp_arrive;

    assign w_ready_o = (state_q == ST_WRITE) && !done_q;
    assign w_fire    = w_valid_i && w_ready_o;
    assign rd_issue  = (state_q == ST_READ) && !done_q && ((occ < 2'd2) || r_pop);
    assign beat_fire = w_fire || rd_issue;
    assign beat_last = (cnt_q == '0) || (w_fire && w_last_i);

    assign mem.req   = beat_fire && !oor;
    assign mem.we    = (state_q == ST_WRITE);
    assign mem.idx   = MEM_IDX_W'(addr_q >> $clog2(AXI_STRB_W));
    assign mem.wdata = w_data_i;
    assign mem.strb  = w_strb_i;

    assign b_valid_o = (state_q == ST_WRESP);
    assign b_id_o    = id_q;
    assign b_resp_o  = err_q ? RESP_DECERR : RESP_OKAY;

    assign r_valid_o = (fifo_cnt_q != '0);
    assign r_id_o    = id_q;
    assign r_data_o  = fifo_data_q[rd_ptr_q];
    assign r_resp_o  = fifo_resp_q[rd_ptr_q];
    assign r_last_o  = fifo_last_q[rd_ptr_q];

    axi_burst_addr i_burst_addr (
        .addr_i      (addr_q),
        .size_i      (size_q),
        .len_i       (len_q),
        .burst_i     (burst_q),
        .next_addr_o (next_addr)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            rr_rd_q     <= 1'b0;
            done_q      <= 1'b0;
            err_q       <= 1'b0;
            derr_q      <= 1'b0;
            last_pend_q <= 1'b0;
            wr_ptr_q    <= 1'b0;
            rd_ptr_q    <= 1'b0;
            fifo_cnt_q  <= '0;
        end else begin
            derr_q      <= beat_fire && oor;
            last_pend_q <= beat_fire && beat_last;
            fifo_cnt_q  <= fifo_cnt_q + 2'(r_push) - 2'(r_pop);
            if (r_push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (r_pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            if (beat_fire && oor) begin
                err_q <= 1'b1;
            end
            if (beat_fire && beat_last) begin
                done_q <= 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    done_q <= 1'b0;
                    err_q  <= 1'b0;
                    if (aw_fire) begin
                        state_q <= ST_WRITE;
                        rr_rd_q <= 1'b0;
                    end else if (ar_fire) begin
                        state_q <= ST_READ;
                        rr_rd_q <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (last_pend_q && resp_arrive) begin
                        state_q <= ST_WRESP;  // Last beat acknowledged.
                    end
                end
                ST_WRESP: begin
                    if (b_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (r_pop && r_last_o) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            id_q    <= aw_id_i;
            addr_q  <= aw_addr_i;
            len_q   <= aw_len_i;
            cnt_q   <= aw_len_i;
            size_q  <= aw_size_i;
            burst_q <= aw_burst_i;
        end else if (ar_fire) begin
            id_q    <= ar_id_i;
            addr_q  <= ar_addr_i;
            len_q   <= ar_len_i;
            cnt_q   <= ar_len_i;
            size_q  <= ar_size_i;
            burst_q <= ar_burst_i;
        end else if (beat_fire) begin
            addr_q <= next_addr;
            cnt_q  <= cnt_q - 1'b1;
        end
        if (r_push) begin
            fifo_data_q[wr_ptr_q] <= derr_q ? '0 : mem.rdata;  // Decode error reads zero.
            fifo_resp_q[wr_ptr_q] <= derr_q ? RESP_DECERR : RESP_OKAY;
            fifo_last_q[wr_ptr_q] <= last_pend_q;
        end
    end

endmodule

// ==== hdl/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if import axi_mem_pkg::*; ();

    logic                 req;
    logic                 gnt;
    logic                 we;
    logic [MEM_IDX_W-1:0] idx;    // Index of a 64-bit word.
    data_t                wdata;
    strb_t                strb;
    logic                 rvalid; // Read data or write acknowledge.
    data_t                rdata;

    modport requester (
        output req,
        output we,
        output idx,
        output wdata,
        output strb,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport memory (
        input  req,
        input  we,
        input  idx,
        input  wdata,
        input  strb,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

// ==== src.f ====
hdl/axi_mem_pkg.sv
hdl/mem_bus_if.sv
hdl/axi_burst_addr.sv
hdl/axi_to_mem.sv
hdl/axi_mem_model.sv
hdl/axi_mem_top.sv
test/tb_clk_gen.sv
test/tb_axi_mem.sv

// ==== test/tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem import axi_mem_pkg::*; #(
    parameter int unsigned SEED = 32'h6afb_d518
);

    localparam int MEM_BYTES = MEM_WORDS * AXI_STRB_W;
    localparam int DRV_DLY   = 1;

    logic                  clk_i;
    logic                  rst_n_i;
    id_t                   s_axi_awid_i;
    addr_t                 s_axi_awaddr_i;
    logic [AXI_LEN_W-1:0]  s_axi_awlen_i;
    logic [AXI_SIZE_W-1:0] s_axi_awsize_i;
    logic [1:0]            s_axi_awburst_i;
    logic                  s_axi_awvalid_i;
    logic                  s_axi_awready_o;
    data_t                 s_axi_wdata_i;
    strb_t                 s_axi_wstrb_i;
    logic                  s_axi_wlast_i;
    logic                  s_axi_wvalid_i;
    logic                  s_axi_wready_o;
    id_t                   s_axi_bid_o;
    logic [1:0]            s_axi_bresp_o;
    logic                  s_axi_bvalid_o;
    logic                  s_axi_bready_i;
    id_t                   s_axi_arid_i;
    addr_t                 s_axi_araddr_i;
    logic [AXI_LEN_W-1:0]  s_axi_arlen_i;
    logic [AXI_SIZE_W-1:0] s_axi_arsize_i;
    logic [1:0]            s_axi_arburst_i;
    logic                  s_axi_arvalid_i;
    logic                  s_axi_arready_o;
    id_t                   s_axi_rid_o;
    data_t                 s_axi_rdata_o;
    logic [1:0]            s_axi_rresp_o;
    logic                  s_axi_rlast_o;
    logic                  s_axi_rvalid_o;
    logic                  s_axi_rready_i;

    logic [7:0] ref_mem [0:65535];  // Mirror of the whole address space.
    integer     seed;
    integer     data_seed;
    int         errors      = 0;
    int         checks      = 0;
    int         cycles      = 0;
    int         beats_total = 0;
    string      test_name   = "reset";
    data_t      exp_rdata_q [$];
    logic [1:0] exp_rresp_q [$];
    id_t        exp_rid_q [$];
    logic       exp_rlast_q [$];
    id_t        exp_bid_q [$];
    logic [1:0] exp_bresp_q [$];

    tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

    axi_mem_top i_dut (.*);

    // Address of beat n under the FIXED, INCR and WRAP rules.
    function automatic addr_t beat_addr(addr_t start, int size, int len, burst_e burst, int n);
        int unsigned bytes;
        int unsigned aligned;
        int unsigned window;
        int unsigned base;
        bytes   = 1 << size;
        aligned = start & ~(bytes - 1);
        window  = (len + 1) * bytes;
        base    = start & ~(window - 1);
        if (burst == BURST_FIXED || n == 0) begin
            return start;
        end
        if (burst == BURST_WRAP) begin
            return addr_t'(base + (aligned - base + n * bytes) % window);
        end
        return addr_t'(aligned + n * bytes);
    endfunction

    function automatic data_t ref_word(addr_t addr);
        data_t       word;
        int unsigned base;
        base = addr & ~(AXI_STRB_W - 1);
        for (int b = 0; b < AXI_STRB_W; b++) begin
            word[b*8 +: 8] = ref_mem[base + b];
        end
        return word;
    endfunction

    // Byte lanes that a beat of the given size may use at this address.
    function automatic strb_t lane_mask(addr_t addr, int size);
        int unsigned lo;
        int unsigned hi;
        strb_t       mask;
        lo   = addr % AXI_STRB_W;
        hi   = ((addr & ~((1 << size) - 1)) + (1 << size) - 1) % AXI_STRB_W;
        mask = '0;
        for (int b = lo; b <= hi; b++) begin
            mask[b] = 1'b1;
        end
        return mask;
    endfunction

    task automatic write_burst(input id_t id, input addr_t addr, input int len, input int size,
                               input burst_e burst, input strb_t strb_pat);
        data_t      data [16];
        strb_t      strb [16];
        addr_t      a;
        logic [1:0] bresp;
        bresp = RESP_OKAY;
        for (int n = 0; n <= len; n++) begin
            a       = beat_addr(addr, size, len, burst, n);
            data[n] = {$random(data_seed), $random(data_seed)};
            strb[n] = lane_mask(a, size) & strb_pat;
            if (a >= MEM_BYTES) begin
                bresp = RESP_DECERR;  // Write is dropped.
            end else begin
                for (int b = 0; b < AXI_STRB_W; b++) begin
                    if (strb[n][b]) begin
                        ref_mem[(a & ~16'h7) + b] = data[n][b*8 +: 8];
                    end
                end
            end
        end
        exp_bid_q.push_back(id);
        exp_bresp_q.push_back(bresp);
        beats_total += len + 1;
        @(posedge clk_i);
        #(DRV_DLY);
        s_axi_awid_i    = id;
        s_axi_awaddr_i  = addr;
        s_axi_awlen_i   = AXI_LEN_W'(len);
        s_axi_awsize_i  = AXI_SIZE_W'(size);
        s_axi_awburst_i = burst;
        s_axi_awvalid_i = 1'b1;
        do @(posedge clk_i); while (!s_axi_awready_o);
        #(DRV_DLY);
        s_axi_awvalid_i = 1'b0;
        for (int n = 0; n <= len; n++) begin
            s_axi_wdata_i  = data[n];
            s_axi_wstrb_i  = strb[n];
            s_axi_wlast_i  = (n == len);
            s_axi_wvalid_i = 1'b1;
            do @(posedge clk_i); while (!s_axi_wready_o);
            #(DRV_DLY);
        end
        s_axi_wvalid_i = 1'b0;
        s_axi_wlast_i  = 1'b0;
    endtask

    task automatic read_burst(input id_t id, input addr_t addr, input int len, input int size,
                              input burst_e burst);
        addr_t a;
        for (int n = 0; n <= len; n++) begin
            a = beat_addr(addr, size, len, burst, n);
            exp_rdata_q.push_back(a >= MEM_BYTES ? data_t'(0) : ref_word(a));
            exp_rresp_q.push_back(a >= MEM_BYTES ? RESP_DECERR : RESP_OKAY);
            exp_rid_q.push_back(id);
            exp_rlast_q.push_back(n == len);
        end
        beats_total += len + 1;
        @(posedge clk_i);
        #(DRV_DLY);
        s_axi_arid_i    = id;
        s_axi_araddr_i  = addr;
        s_axi_arlen_i   = AXI_LEN_W'(len);
        s_axi_arsize_i  = AXI_SIZE_W'(size);
        s_axi_arburst_i = burst;
        s_axi_arvalid_i = 1'b1;
        do @(posedge clk_i); while (!s_axi_arready_o);
        #(DRV_DLY);
        s_axi_arvalid_i = 1'b0;
    endtask

    // Random back-pressure on R and B.
    initial begin
        seed           = SEED;
        s_axi_rready_i = 1'b0;
        s_axi_bready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #(DRV_DLY);
            s_axi_rready_i = ($random(seed) & 3) != 0;
            s_axi_bready_i = ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 40 * beats_total + 200) begin
            $display("ERROR %s: timeout after %0d cycles, bursts did not complete",
                     test_name, cycles);
            errors++;
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge clk_i) begin : check_responses
        data_t      exp_data;
        logic [1:0] exp_resp;
        id_t        exp_id;
        logic       exp_last;
        if (rst_n_i && s_axi_rvalid_o && s_axi_rready_i) begin
            if (exp_rdata_q.size() == 0) begin
                $display("ERROR %s: R beat arrived with no read beat outstanding", test_name);
                errors++;
            end else begin
                exp_data = exp_rdata_q.pop_front();
                exp_resp = exp_rresp_q.pop_front();
                exp_id   = exp_rid_q.pop_front();
                exp_last = exp_rlast_q.pop_front();
                checks++;
                if (s_axi_rdata_o !== exp_data) begin
                    $display("FAIL %s rdata: expected %h, actual %h",
                             test_name, exp_data, s_axi_rdata_o);
                    errors++;
                end
                if (s_axi_rresp_o !== exp_resp) begin
                    $display("FAIL %s rresp: expected %0d, actual %0d",
                             test_name, exp_resp, s_axi_rresp_o);
                    errors++;
                end
                if (s_axi_rid_o !== exp_id) begin
                    $display("FAIL %s rid: expected %h, actual %h", test_name, exp_id, s_axi_rid_o);
                    errors++;
                end
                if (s_axi_rlast_o !== exp_last) begin
                    $display("FAIL %s rlast: expected %b, actual %b",
                             test_name, exp_last, s_axi_rlast_o);
                    errors++;
                end
            end
        end
        if (rst_n_i && s_axi_bvalid_o && s_axi_bready_i) begin
            if (exp_bresp_q.size() == 0) begin
                $display("ERROR %s: B response arrived with no write outstanding", test_name);
                errors++;
            end else begin
                exp_id   = exp_bid_q.pop_front();
                exp_resp = exp_bresp_q.pop_front();
                checks++;
                if (s_axi_bid_o !== exp_id) begin
                    $display("FAIL %s bid: expected %h, actual %h", test_name, exp_id, s_axi_bid_o);
                    errors++;
                end
                if (s_axi_bresp_o !== exp_resp) begin
                    $display("FAIL %s bresp: expected %0d, actual %0d",
                             test_name, exp_resp, s_axi_bresp_o);
                    errors++;
                end
            end
        end
    end

    initial begin
        addr_t a;
        addr_t r_addr;
        int    len;
        int    len2;
        data_seed       = SEED + 1;
        s_axi_awid_i    = '0;
        s_axi_awaddr_i  = '0;
        s_axi_awlen_i   = '0;
        s_axi_awsize_i  = '0;
        s_axi_awburst_i = '0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i   = '0;
        s_axi_wstrb_i   = '0;
        s_axi_wlast_i   = 1'b0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_arid_i    = '0;
        s_axi_araddr_i  = '0;
        s_axi_arlen_i   = '0;
        s_axi_arsize_i  = '0;
        s_axi_arburst_i = '0;
        s_axi_arvalid_i = 1'b0;
        while (rst_n_i !== 1'b1) begin
            @(posedge clk_i);
        end
        @(posedge clk_i);
        checks += 3;
        if (s_axi_rvalid_o !== 1'b0) begin
            $display("FAIL %s rvalid: expected 0, actual %b", test_name, s_axi_rvalid_o);
            errors++;
        end
        if (s_axi_bvalid_o !== 1'b0) begin
            $display("FAIL %s bvalid: expected 0, actual %b", test_name, s_axi_bvalid_o);
            errors++;
        end
        if (s_axi_wready_o !== 1'b0) begin
            $display("FAIL %s wready: expected 0, actual %b", test_name, s_axi_wready_o);
            errors++;
        end

        test_name = "fill";  // Known contents everywhere before any read.
        for (int i = 0; i < MEM_WORDS / 16; i++) begin
            write_burst(4'(i), addr_t'(i * 128), 15, 3, BURST_INCR, '1);
        end

        test_name = "strobe";
        write_burst(4'h1, 16'h0100, 0, 3, BURST_INCR, 8'h0f);
        write_burst(4'h2, 16'h0100, 0, 3, BURST_INCR, 8'h30);
        write_burst(4'h3, 16'h0108, 0, 3, BURST_INCR, 8'h81);
        read_burst(4'h4, 16'h0100, 1, 3, BURST_INCR);

        test_name = "incr";
        for (int i = 0; i < 8; i++) begin
            len  = $random(data_seed) & 15;
            len2 = $random(data_seed) & 15;
            a    = addr_t'($random(data_seed) & 32'h1f78);
            write_burst(4'(i), a, len, 3, BURST_INCR, '1);
            read_burst(4'(i + 8), a, len2, 3, BURST_INCR);
        end

        test_name = "wrap";  // Start is never on a window boundary.
        for (int k = 0; k < 4; k++) begin
            len = (2 << k) - 1;
            a   = addr_t'(16'h0408 + ($random(data_seed) & 32'h70));
            write_burst(4'(k), a, len, 3, BURST_WRAP, '1);
            read_burst(4'(k), a & ~addr_t'((len + 1) * 8 - 1), len, 3, BURST_INCR);
            read_burst(4'(k + 4), a, len, 3, BURST_WRAP);
        end

        test_name = "fixed";
        write_burst(4'h9, 16'h0600, 3, 3, BURST_FIXED, '1);
        read_burst(4'ha, 16'h05f8, 2, 3, BURST_INCR);
        read_burst(4'hb, 16'h0600, 3, 3, BURST_FIXED);

        test_name = "narrow";
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < 2; i++) begin
                len = $random(data_seed) & 15;
                a   = addr_t'(16'h0801 + ($random(data_seed) & 32'h3fe));
                write_burst(4'(s), a, len, s, BURST_INCR, '1);
                read_burst(4'(s), a, len, s, BURST_INCR);
                read_burst(4'(s + 4), a & ~addr_t'(7), 15, 3, BURST_INCR);
            end
        end

        test_name = "decerr";  // Memory ends at 16'h2000.
        write_burst(4'h6, 16'h1fc0, 15, 3, BURST_INCR, '1);
        read_burst(4'h7, 16'h1fc0, 15, 3, BURST_INCR);
        read_burst(4'h8, 16'h3000, 3, 3, BURST_INCR);
        write_burst(4'h9, 16'h1ff4, 7, 2, BURST_INCR, '1);
        read_burst(4'ha, 16'h1fc0, 7, 3, BURST_INCR);

        test_name = "concurrent";
        for (int i = 0; i < 12; i++) begin
            len    = $random(data_seed) & 15;
            len2   = $random(data_seed) & 15;
            a      = addr_t'($random(data_seed) & 32'h0778);
            r_addr = addr_t'(16'h1000 + ($random(data_seed) & 32'h0778));
            fork
                write_burst(4'(i), a, len, 3, BURST_INCR, '1);
                read_burst(4'(i), r_addr, len2, 3, BURST_INCR);
            join
        end
        for (int i = 0; i < 16; i++) begin
            read_burst(4'(i), addr_t'(i * 128), 15, 3, BURST_INCR);
        end

        test_name = "drain";
        while (exp_rdata_q.size() != 0 || exp_bresp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);  // Catch stray beats.
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 10 ns period.
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule
